// File: logic/rs_settings.svh
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// Register and address value width
// Also the width of the load/store address sum
`define GPR_SIZE 64

// ROB tag width
// 5 bits cover 32 in-flight instructions
`define ROB_IDX_SIZE 5

// Default entry count of one station
// Keep a power of two so slot indices cover every entry
`define RS_DEPTH 8

// The ALU and load/store stations both use `RS_DEPTH
// unless the top level overrides it

`endif

// File: logic/rs_pkg.sv
`include "rs_settings.svh"

package rs_pkg;

  // Register or address value
  typedef logic [`GPR_SIZE-1:0] word_t;

  // ROB tag, names a producer on the broadcast
  typedef logic [`ROB_IDX_SIZE-1:0] rob_idx_t;

  // Condition flags in N, Z, C, V order
  typedef logic [3:0] nzcv_t;

  // Condition code for CSEL and branches
  typedef logic [3:0] cond_t;

  // Functional unit selector
  typedef logic [0:0] fu_t;

  localparam fu_t FU_ALU = 1'b0;
  localparam fu_t FU_LS  = 1'b1;

  // Operation code
  typedef logic [3:0] fu_op_t;

  // ALU operations
  localparam fu_op_t FU_OP_ADD  = 4'd0;
  localparam fu_op_t FU_OP_SUB  = 4'd1;
  localparam fu_op_t FU_OP_AND  = 4'd2;
  localparam fu_op_t FU_OP_ORR  = 4'd3;
  localparam fu_op_t FU_OP_CSEL = 4'd4;

  // Memory operations
  // Operand A carries the offset until the base arrives
  localparam fu_op_t FU_OP_LDUR = 4'd5;
  localparam fu_op_t FU_OP_STUR = 4'd6;

endpackage

// File: logic/rs_slot_pick.sv
`timescale 1ns/1ps

// Lowest-index priority encoder over a bitmap
module rs_slot_pick #(
  parameter int DEPTH = 8
) (
  input  logic [DEPTH-1:0]         bitmap,
  output logic [$clog2(DEPTH)-1:0] index,
  output logic                     found
);

  localparam int IDX_W = $clog2(DEPTH);

  logic [IDX_W-1:0] pick;

  // Any set bit at all
  assign found = |bitmap;

  // Walk downward so the lowest set bit is written last
  always_comb begin
    pick = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (bitmap[i]) begin
        pick = IDX_W'(i);
      end
    end
  end

  // Index is zero when nothing is set, qualify with found
  assign index = pick;

endmodule

// File: logic/reservation_station.sv
`timescale 1ns/1ps
`include "rs_settings.svh"

module reservation_station #(
  parameter int RS_SIZE = `RS_DEPTH
) (
  input  logic             in_clk,
  input  logic             rst_n,
  // Dispatch
  input  logic             disp_valid,
  input  rs_pkg::fu_op_t   disp_op,
  input  rs_pkg::rob_idx_t disp_dst_index,
  input  logic             disp_val_a_valid,
  input  rs_pkg::word_t    disp_val_a_value,
  input  rs_pkg::rob_idx_t disp_val_a_index,
  input  logic             disp_val_b_valid,
  input  rs_pkg::word_t    disp_val_b_value,
  input  rs_pkg::rob_idx_t disp_val_b_index,
  input  logic             disp_uses_nzcv,
  input  logic             disp_nzcv_valid,
  input  rs_pkg::nzcv_t    disp_nzcv,
  input  rs_pkg::rob_idx_t disp_nzcv_index,
  input  logic             disp_set_nzcv,
  input  rs_pkg::cond_t    disp_cond,
  // Result broadcast
  input  logic             bc_done,
  input  rs_pkg::rob_idx_t bc_index,
  input  rs_pkg::word_t    bc_value,
  input  logic             bc_set_nzcv,
  input  rs_pkg::nzcv_t    bc_nzcv,
  // Mispredict
  input  logic             flush,
  // Issue handshake
  input  logic             fu_ready,
  output logic             full,
  output logic             start,
  // Issued instruction
  output rs_pkg::fu_op_t   issue_op,
  output rs_pkg::word_t    issue_val_a,
  output rs_pkg::word_t    issue_val_b,
  output rs_pkg::rob_idx_t issue_dst_index,
  output logic             issue_set_nzcv,
  output rs_pkg::nzcv_t    issue_nzcv,
  output rs_pkg::cond_t    issue_cond
);

  import rs_pkg::*;

  localparam int IDX_W = $clog2(RS_SIZE);

  typedef logic [IDX_W-1:0] slot_t;

  // Entry occupancy and readiness flags
  logic [RS_SIZE-1:0] ent_valid;
  logic [RS_SIZE-1:0] a_valid;
  logic [RS_SIZE-1:0] b_valid;
  logic [RS_SIZE-1:0] f_uses;
  logic [RS_SIZE-1:0] f_valid;

  // Entry payload
  fu_op_t   ent_op       [RS_SIZE];
  rob_idx_t ent_dst      [RS_SIZE];
  logic     ent_set_nzcv [RS_SIZE];
  cond_t    ent_cond     [RS_SIZE];
  word_t    a_value      [RS_SIZE];
  rob_idx_t a_index      [RS_SIZE];
  word_t    b_value      [RS_SIZE];
  rob_idx_t b_index      [RS_SIZE];
  nzcv_t    f_value      [RS_SIZE];
  rob_idx_t f_index      [RS_SIZE];

  logic [RS_SIZE-1:0] free_map;
  logic [RS_SIZE-1:0] ready_map;
  logic [RS_SIZE-1:0] mem_map;
  slot_t              free_idx;
  slot_t              ready_idx;
  logic               free_found;
  logic               ready_found;
  logic               disp_we;

  // Dispatch fields after same-edge bypass
  logic  disp_mem;
  logic  byp_a;
  logic  byp_b;
  logic  byp_f;
  word_t new_a_value;
  word_t new_b_value;
  nzcv_t new_f_value;

  always_comb begin
    for (int i = 0; i < RS_SIZE; i++) begin
      mem_map[i]   = (ent_op[i] == FU_OP_LDUR) || (ent_op[i] == FU_OP_STUR);
      ready_map[i] = ent_valid[i] && a_valid[i] && b_valid[i] && (!f_uses[i] || f_valid[i]);
    end
  end

  assign free_map = ~ent_valid;

  rs_slot_pick #(.DEPTH(RS_SIZE)) free_pick_i (
    .bitmap (free_map),
    .index  (free_idx),
    .found  (free_found)
  );

  rs_slot_pick #(.DEPTH(RS_SIZE)) ready_pick_i (
    .bitmap (ready_map),
    .index  (ready_idx),
    .found  (ready_found)
  );

  assign full    = !free_found;
  assign start   = fu_ready && ready_found && !flush;
  assign disp_we = disp_valid && free_found && !flush;

  // Broadcast landing on the dispatch edge
  assign disp_mem = (disp_op == FU_OP_LDUR) || (disp_op == FU_OP_STUR);
  assign byp_a    = bc_done && !disp_val_a_valid && (disp_val_a_index == bc_index);
  assign byp_b    = bc_done && !disp_val_b_valid && (disp_val_b_index == bc_index);
  assign byp_f    = bc_done && bc_set_nzcv && disp_uses_nzcv && !disp_nzcv_valid &&
                    (disp_nzcv_index == bc_index);

  // Memory ops add the base to the offset held in operand A
  assign new_a_value = !byp_a   ? disp_val_a_value :
                       disp_mem ? disp_val_a_value + bc_value : bc_value;
  assign new_b_value = byp_b ? bc_value : disp_val_b_value;
  assign new_f_value = byp_f ? bc_nzcv : disp_nzcv;

  // Occupancy, flush wins over issue and dispatch
  always_ff @(posedge in_clk or negedge rst_n) begin
    if (!rst_n) begin
      ent_valid <= '0;
    end else if (flush) begin
      ent_valid <= '0;
    end else begin
      if (start) begin
        ent_valid[ready_idx] <= 1'b0;
      end
      // Free map excludes the slot issued this edge
      if (disp_we) begin
        ent_valid[free_idx] <= 1'b1;
      end
    end
  end

  // Insert and wakeup
  always_ff @(posedge in_clk) begin
    for (int i = 0; i < RS_SIZE; i++) begin
      if (disp_we && (free_idx == slot_t'(i))) begin
        ent_op[i]       <= disp_op;
        ent_dst[i]      <= disp_dst_index;
        ent_set_nzcv[i] <= disp_set_nzcv;
        ent_cond[i]     <= disp_cond;
        a_valid[i]      <= disp_val_a_valid || byp_a;
        a_value[i]      <= new_a_value;
        a_index[i]      <= disp_val_a_index;
        b_valid[i]      <= disp_val_b_valid || byp_b;
        b_value[i]      <= new_b_value;
        b_index[i]      <= disp_val_b_index;
        f_uses[i]       <= disp_uses_nzcv;
        f_valid[i]      <= disp_nzcv_valid || byp_f;
        f_value[i]      <= new_f_value;
        f_index[i]      <= disp_nzcv_index;
      end else if (bc_done && ent_valid[i]) begin
        // Only pending operands listen, so an address sums once
        if (!a_valid[i] && (a_index[i] == bc_index)) begin
          a_valid[i] <= 1'b1;
          a_value[i] <= mem_map[i] ? a_value[i] + bc_value : bc_value;
        end
        if (!b_valid[i] && (b_index[i] == bc_index)) begin
          b_valid[i] <= 1'b1;
          b_value[i] <= bc_value;
        end
        if (f_uses[i] && !f_valid[i] && bc_set_nzcv && (f_index[i] == bc_index)) begin
          f_valid[i] <= 1'b1;
          f_value[i] <= bc_nzcv;
        end
      end
    end
  end

  // Selected entry, meaningful while start is high
  assign issue_op        = ent_op[ready_idx];
  assign issue_val_a     = a_value[ready_idx];
  assign issue_val_b     = b_value[ready_idx];
  assign issue_dst_index = ent_dst[ready_idx];
  assign issue_set_nzcv  = ent_set_nzcv[ready_idx];
  assign issue_nzcv      = f_value[ready_idx];
  assign issue_cond      = ent_cond[ready_idx];

endmodule

// File: logic/issue_stage.sv
`timescale 1ns/1ps
`include "rs_settings.svh"

module issue_stage (
  input  logic             in_clk,
  input  logic             rst_n,
  // Dispatch from the ROB
  input  logic             rob_done,
  input  rs_pkg::fu_t      rob_fu_id,
  input  rs_pkg::fu_op_t   rob_fu_op,
  input  rs_pkg::rob_idx_t rob_dst_index,
  input  logic             rob_val_a_valid,
  input  rs_pkg::word_t    rob_val_a_value,
  input  rs_pkg::rob_idx_t rob_val_a_index,
  input  logic             rob_val_b_valid,
  input  rs_pkg::word_t    rob_val_b_value,
  input  rs_pkg::rob_idx_t rob_val_b_index,
  input  logic             rob_uses_nzcv,
  input  logic             rob_nzcv_valid,
  input  rs_pkg::nzcv_t    rob_nzcv,
  input  rs_pkg::rob_idx_t rob_nzcv_index,
  input  logic             rob_set_nzcv,
  input  rs_pkg::cond_t    rob_cond,
  input  logic             rob_mispred,
  // Result broadcast
  input  logic             bc_done,
  input  rs_pkg::rob_idx_t bc_index,
  input  rs_pkg::word_t    bc_value,
  input  logic             bc_set_nzcv,
  input  rs_pkg::nzcv_t    bc_nzcv,
  // Functional unit handshake
  input  logic             alu_ready,
  input  logic             ls_ready,
  output logic             alu_full,
  output logic             ls_full,
  // ALU issue
  output logic             alu_start,
  output rs_pkg::fu_op_t   alu_op,
  output rs_pkg::word_t    alu_val_a,
  output rs_pkg::word_t    alu_val_b,
  output rs_pkg::rob_idx_t alu_dst_index,
  output logic             alu_set_nzcv,
  output rs_pkg::nzcv_t    alu_nzcv,
  output rs_pkg::cond_t    alu_cond,
  // Load/store issue
  output logic             ls_start,
  output rs_pkg::fu_op_t   ls_op,
  output rs_pkg::word_t    ls_val_a,
  output rs_pkg::word_t    ls_val_b,
  output rs_pkg::rob_idx_t ls_dst_index
);

  import rs_pkg::*;

  logic alu_disp;
  logic ls_disp;

  // Steer by unit
  assign alu_disp = rob_done && (rob_fu_id == FU_ALU);
  assign ls_disp  = rob_done && (rob_fu_id == FU_LS);

  reservation_station #(.RS_SIZE(`RS_DEPTH)) alu_rs_i (
    .in_clk           (in_clk),
    .rst_n            (rst_n),
    .disp_valid       (alu_disp),
    .disp_op          (rob_fu_op),
    .disp_dst_index   (rob_dst_index),
    .disp_val_a_valid (rob_val_a_valid),
    .disp_val_a_value (rob_val_a_value),
    .disp_val_a_index (rob_val_a_index),
    .disp_val_b_valid (rob_val_b_valid),
    .disp_val_b_value (rob_val_b_value),
    .disp_val_b_index (rob_val_b_index),
    .disp_uses_nzcv   (rob_uses_nzcv),
    .disp_nzcv_valid  (rob_nzcv_valid),
    .disp_nzcv        (rob_nzcv),
    .disp_nzcv_index  (rob_nzcv_index),
    .disp_set_nzcv    (rob_set_nzcv),
    .disp_cond        (rob_cond),
    .bc_done          (bc_done),
    .bc_index         (bc_index),
    .bc_value         (bc_value),
    .bc_set_nzcv      (bc_set_nzcv),
    .bc_nzcv          (bc_nzcv),
    .flush            (rob_mispred),
    .fu_ready         (alu_ready),
    .full             (alu_full),
    .start            (alu_start),
    .issue_op         (alu_op),
    .issue_val_a      (alu_val_a),
    .issue_val_b      (alu_val_b),
    .issue_dst_index  (alu_dst_index),
    .issue_set_nzcv   (alu_set_nzcv),
    .issue_nzcv       (alu_nzcv),
    .issue_cond       (alu_cond)
  );

  // Flags and condition have no consumer on the memory side
  reservation_station #(.RS_SIZE(`RS_DEPTH)) ls_rs_i (
    .in_clk           (in_clk),
    .rst_n            (rst_n),
    .disp_valid       (ls_disp),
    .disp_op          (rob_fu_op),
    .disp_dst_index   (rob_dst_index),
    .disp_val_a_valid (rob_val_a_valid),
    .disp_val_a_value (rob_val_a_value),
    .disp_val_a_index (rob_val_a_index),
    .disp_val_b_valid (rob_val_b_valid),
    .disp_val_b_value (rob_val_b_value),
    .disp_val_b_index (rob_val_b_index),
    .disp_uses_nzcv   (rob_uses_nzcv),
    .disp_nzcv_valid  (rob_nzcv_valid),
    .disp_nzcv        (rob_nzcv),
    .disp_nzcv_index  (rob_nzcv_index),
    .disp_set_nzcv    (rob_set_nzcv),
    .disp_cond        (rob_cond),
    .bc_done          (bc_done),
    .bc_index         (bc_index),
    .bc_value         (bc_value),
    .bc_set_nzcv      (bc_set_nzcv),
    .bc_nzcv          (bc_nzcv),
    .flush            (rob_mispred),
    .fu_ready         (ls_ready),
    .full             (ls_full),
    .start            (ls_start),
    .issue_op         (ls_op),
    .issue_val_a      (ls_val_a),
    .issue_val_b      (ls_val_b),
    .issue_dst_index  (ls_dst_index),
    .issue_set_nzcv   (),
    .issue_nzcv       (),
    .issue_cond       ()
  );

endmodule

// File: sim/issue_stage_assert.sv
`timescale 1ns/1ps

module issue_stage_assert (
  input logic        in_clk,
  input logic        rst_n,
  input logic        rob_done,
  input rs_pkg::fu_t rob_fu_id,
  input logic        rob_mispred,
  input logic        alu_ready,
  input logic        ls_ready,
  input logic        alu_full,
  input logic        ls_full,
  input logic        alu_start,
  input logic        ls_start
);

  import rs_pkg::*;

  // Count of failed checks
  int fail_count = 0;

  // No issue without a ready unit
  assert property (@(posedge in_clk) disable iff (!rst_n) alu_start |-> alu_ready)
    else begin
      fail_count++;
      $error("alu_start high while alu_ready is low");
    end
  assert property (@(posedge in_clk) disable iff (!rst_n) ls_start |-> ls_ready)
    else begin
      fail_count++;
      $error("ls_start high while ls_ready is low");
    end

  // Flush blocks issue
  assert property (@(posedge in_clk) disable iff (!rst_n)
                   rob_mispred |-> !alu_start && !ls_start)
    else begin
      fail_count++;
      $error("start high during a mispredict");
    end

  // ROB respects the full flags
  assert property (@(posedge in_clk) disable iff (!rst_n)
                   (rob_done && rob_fu_id == FU_ALU) |-> !alu_full)
    else begin
      fail_count++;
      $error("dispatch to the ALU station while it is full");
    end
  assert property (@(posedge in_clk) disable iff (!rst_n)
                   (rob_done && rob_fu_id == FU_LS) |-> !ls_full)
    else begin
      fail_count++;
      $error("dispatch to the load/store station while it is full");
    end

  // Empty stations right after reset
  assert property (@(posedge in_clk) $rose(rst_n) |-> !alu_start && !ls_start)
    else begin
      fail_count++;
      $error("start high in the first cycle after reset");
    end

endmodule

bind issue_stage issue_stage_assert assert_i (.*);

// File: sim/issue_stage_tb.sv
`timescale 1ns/1ps
`include "rs_settings.svh"

module issue_stage_tb;

  import rs_pkg::*;

  localparam int D = `RS_DEPTH;
  localparam int TEST_CYCLES = 5 + 200 + 300 + 200 + 200 + (4 * D + 8) + 323;
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

  logic in_clk, rst_n, rob_done, rob_mispred, alu_ready, ls_ready;
  fu_t      rob_fu_id;
  fu_op_t   rob_fu_op;
  rob_idx_t rob_dst_index, rob_val_a_index, rob_val_b_index, rob_nzcv_index, bc_index;
  logic     rob_val_a_valid, rob_val_b_valid, rob_uses_nzcv, rob_nzcv_valid, rob_set_nzcv;
  word_t    rob_val_a_value, rob_val_b_value, bc_value;
  nzcv_t    rob_nzcv, bc_nzcv;
  cond_t    rob_cond;
  logic     bc_done, bc_set_nzcv;
  logic     alu_full, ls_full, alu_start, ls_start, alu_set_nzcv;
  fu_op_t   alu_op, ls_op;
  word_t    alu_val_a, alu_val_b, ls_val_a, ls_val_b;
  rob_idx_t alu_dst_index, ls_dst_index;
  nzcv_t    alu_nzcv;
  cond_t    alu_cond;

  // Model of both stations with the ALU at index 0
  logic     m_valid [2][D];
  fu_op_t   m_op    [2][D];
  rob_idx_t m_dst   [2][D];
  logic     m_av    [2][D];
  word_t    m_a     [2][D];
  rob_idx_t m_ai    [2][D];
  logic     m_bv    [2][D];
  word_t    m_b     [2][D];
  rob_idx_t m_bi    [2][D];
  logic     m_fu    [2][D];
  logic     m_fv    [2][D];
  nzcv_t    m_f     [2][D];
  rob_idx_t m_fi    [2][D];
  logic     m_set   [2][D];
  cond_t    m_cond  [2][D];

  logic [15:0] lfsr;
  int          errors;
  int          checks;
  int          cycle_count;
  int          e0;

  issue_stage dut_i (.*);

  initial begin
    in_clk = 1'b0;
    forever #2 in_clk = ~in_clk;
  end

  // Run limit
  always @(posedge in_clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Taps 16, 14, 13, 11
  function automatic logic next_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[62:0], next_bit()};
    end
    return r;
  endfunction

  function automatic logic is_mem(input fu_op_t op);
    return (op == FU_OP_LDUR) || (op == FU_OP_STUR);
  endfunction

  function automatic int lowest_free(input int u);
    for (int i = 0; i < D; i++) begin
      if (!m_valid[u][i]) return i;
    end
    return -1;
  endfunction

  function automatic int lowest_ready(input int u);
    for (int i = 0; i < D; i++) begin
      if (m_valid[u][i] && m_av[u][i] && m_bv[u][i] && (!m_fu[u][i] || m_fv[u][i])) return i;
    end
    return -1;
  endfunction

  // Broadcast capture with address accumulation on operand A
  task automatic wake_slot(input int u, input int s);
    if (!m_av[u][s] && m_ai[u][s] == bc_index) begin
      m_av[u][s] = 1'b1;
      m_a[u][s]  = is_mem(m_op[u][s]) ? m_a[u][s] + bc_value : bc_value;
    end
    if (!m_bv[u][s] && m_bi[u][s] == bc_index) begin
      m_bv[u][s] = 1'b1;
      m_b[u][s]  = bc_value;
    end
    if (m_fu[u][s] && !m_fv[u][s] && bc_set_nzcv && m_fi[u][s] == bc_index) begin
      m_fv[u][s] = 1'b1;
      m_f[u][s]  = bc_nzcv;
    end
  endtask

  task automatic insert_slot(input int u, input int s);
    m_valid[u][s] = 1'b1;
    m_op[u][s]    = rob_fu_op;
    m_dst[u][s]   = rob_dst_index;
    m_set[u][s]   = rob_set_nzcv;
    m_cond[u][s]  = rob_cond;
    m_av[u][s]    = rob_val_a_valid;
    m_a[u][s]     = rob_val_a_value;
    m_ai[u][s]    = rob_val_a_index;
    m_bv[u][s]    = rob_val_b_valid;
    m_b[u][s]     = rob_val_b_value;
    m_bi[u][s]    = rob_val_b_index;
    m_fu[u][s]    = rob_uses_nzcv;
    m_fv[u][s]    = rob_nzcv_valid;
    m_f[u][s]     = rob_nzcv;
    m_fi[u][s]    = rob_nzcv_index;
    // Same-edge bypass
    if (bc_done) wake_slot(u, s);
  endtask

  // One clock edge of both stations
  task automatic update_model();
    int   fr;
    int   rd;
    logic rdy [2];
    rdy[0] = alu_ready;
    rdy[1] = ls_ready;
    for (int u = 0; u < 2; u++) begin
      fr = lowest_free(u);
      rd = lowest_ready(u);
      for (int i = 0; i < D; i++) begin
        if (rob_mispred) m_valid[u][i] = 1'b0;
        else if (bc_done && m_valid[u][i]) wake_slot(u, i);
      end
      if (!rob_mispred && rdy[u] && rd >= 0) m_valid[u][rd] = 1'b0;
      if (!rob_mispred && rob_done && int'(rob_fu_id) == u && fr >= 0) insert_slot(u, fr);
    end
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic check_outputs();
    int   ra;
    int   rl;
    logic ea;
    logic el;
    ra = lowest_ready(0);
    rl = lowest_ready(1);
    ea = alu_ready && ra >= 0 && !rob_mispred;
    el = ls_ready && rl >= 0 && !rob_mispred;
    check_value(alu_start, ea, "alu_start");
    check_value(ls_start, el, "ls_start");
    check_value(alu_full, lowest_free(0) < 0, "alu_full");
    check_value(ls_full, lowest_free(1) < 0, "ls_full");
    if (ea) begin
      check_value(alu_op, m_op[0][ra], "alu_op");
      check_value(alu_val_a, m_a[0][ra], "alu_val_a");
      check_value(alu_val_b, m_b[0][ra], "alu_val_b");
      check_value(alu_dst_index, m_dst[0][ra], "alu_dst_index");
      check_value(alu_set_nzcv, m_set[0][ra], "alu_set_nzcv");
      check_value(alu_nzcv, m_f[0][ra], "alu_nzcv");
      check_value(alu_cond, m_cond[0][ra], "alu_cond");
    end
    if (el) begin
      check_value(ls_op, m_op[1][rl], "ls_op");
      check_value(ls_val_a, m_a[1][rl], "ls_val_a");
      check_value(ls_val_b, m_b[1][rl], "ls_val_b");
      check_value(ls_dst_index, m_dst[1][rl], "ls_dst_index");
    end
  endtask

  // Kind 0 idle, 1 all valid, 2 pending, 3 pending base, 4 flags, 5 forced fill
  task automatic pick_inputs(input int kind, input int unit_sel, input logic stall,
                             input logic flush_ok);
    fu_t  u;
    logic pend;
    u    = (unit_sel == 2) ? fu_t'(rand_bits(1)) : fu_t'(unit_sel);
    pend = (kind >= 2) && (kind <= 4);
    rob_fu_id       = u;
    rob_done        = (kind != 0) && (kind == 5 || rand_bits(2) != 0) &&
                      lowest_free(int'(u)) >= 0;
    rob_dst_index   = rob_idx_t'(rand_bits(5));
    rob_val_a_valid = (kind == 3) ? (rand_bits(2) == 0) : (!pend || rand_bits(1) != 0);
    rob_val_a_value = rand_bits(64);
    rob_val_a_index = rob_idx_t'(rand_bits(3));
    rob_val_b_valid = !pend || rand_bits(1) != 0;
    rob_val_b_value = rand_bits(64);
    rob_val_b_index = rob_idx_t'(rand_bits(3));
    if (u == FU_LS) rob_fu_op = (rand_bits(1) != 0) ? FU_OP_STUR : FU_OP_LDUR;
    else if (kind == 4) rob_fu_op = FU_OP_CSEL;
    else rob_fu_op = fu_op_t'(rand_bits(2));
    rob_uses_nzcv  = (u == FU_ALU) && (rob_fu_op == FU_OP_CSEL || rand_bits(2) == 0);
    rob_nzcv_valid = !pend || rand_bits(1) != 0;
    rob_nzcv       = nzcv_t'(rand_bits(4));
    rob_nzcv_index = rob_idx_t'(rand_bits(3));
    rob_set_nzcv   = rand_bits(1) != 0;
    rob_cond       = cond_t'(rand_bits(4));
    bc_done        = pend && rand_bits(1) != 0;
    bc_index       = rob_idx_t'(rand_bits(3));
    bc_value       = rand_bits(64);
    bc_set_nzcv    = rand_bits(1) != 0;
    bc_nzcv        = nzcv_t'(rand_bits(4));
    alu_ready      = !stall && rand_bits(3) != 0;
    ls_ready       = !stall && rand_bits(3) != 0;
    rob_mispred    = flush_ok && rand_bits(5) == 0;
  endtask

  // Check mid-cycle and step the model at the edge, then drive 1 ns later
  task automatic step_cycle();
    @(negedge in_clk);
    check_outputs();
    @(posedge in_clk);
    update_model();
    #1;
  endtask

  task automatic run_phase(input int kind, input int unit_sel, input logic stall,
                           input logic flush_ok, input int n);
    for (int c = 0; c < n; c++) begin
      pick_inputs(kind, unit_sel, stall, flush_ok);
      step_cycle();
    end
  endtask

  task automatic report_test(input string name, input int first_error);
    $display("test %-14s errors %0d", name, errors - first_error);
  endtask

  initial begin
    lfsr = 16'd43439;
    errors = 0;
    checks = 0;
    cycle_count = 0;
    rst_n = 1'b0;
    for (int u = 0; u < 2; u++) begin
      for (int i = 0; i < D; i++) m_valid[u][i] = 1'b0;
    end
    pick_inputs(0, 0, 1'b1, 1'b0);
    repeat (5) @(posedge in_clk);
    #1 rst_n = 1'b1;

    e0 = errors;
    run_phase(1, 2, 1'b0, 1'b0, 200);
    report_test("ready_issue", e0);
    e0 = errors;
    run_phase(2, 2, 1'b0, 1'b0, 300);
    report_test("wakeup_bypass", e0);
    e0 = errors;
    run_phase(3, 1, 1'b0, 1'b0, 200);
    report_test("ls_address", e0);
    e0 = errors;
    run_phase(4, 0, 1'b0, 1'b0, 200);
    report_test("alu_flags", e0);

    // Fill both stations under stall, then drain
    e0 = errors;
    run_phase(5, 0, 1'b1, 1'b0, D);
    run_phase(5, 1, 1'b1, 1'b0, D);
    check_value(alu_full, 1'b1, "alu_full after fill");
    check_value(ls_full, 1'b1, "ls_full after fill");
    run_phase(0, 2, 1'b0, 1'b0, 2 * D + 8);
    report_test("backpressure", e0);

    e0 = errors;
    run_phase(2, 2, 1'b0, 1'b1, 300);
    run_phase(2, 2, 1'b1, 1'b0, 12);
    pick_inputs(0, 2, 1'b0, 1'b0);
    rob_mispred = 1'b1;
    step_cycle();
    run_phase(0, 2, 1'b0, 1'b0, 10);
    report_test("flush", e0);

    $display("tests 6, checks %0d, errors %0d, assertion failures %0d", checks, errors,
             dut_i.assert_i.fail_count);
    if (errors == 0 && dut_i.assert_i.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+logic
logic/rs_pkg.sv
logic/rs_slot_pick.sv
logic/reservation_station.sv
logic/issue_stage.sv
sim/issue_stage_assert.sv
sim/issue_stage_tb.sv
